/* bench/core_model.sv */
`timescale 1ns/1ps
`default_nettype none

module core_model #(
    parameter cpu_pkg::word_t RESET_PC = '0
) ();

    cpu_pkg::word_t    imem [256];       // Loaded by the testbench
    cpu_pkg::word_t    dmem [64];        // Same initial fill as the bench
    cpu_pkg::word_t    regs [32];
    cpu_pkg::reg_idx_t exp_rd [256];     // Expected writes, in order
    cpu_pkg::word_t    exp_wdata [256];
    cpu_pkg::word_t    st_addr [256];    // Expected stores, in order
    cpu_pkg::word_t    st_data [256];
    int                n_writes;
    int                n_stores;
    logic              reached_loop;

    ////////////////////
    // In-order execution
    ////////////////////
    task automatic run();
        cpu_pkg::word_t    pc;
        cpu_pkg::word_t    next_pc;
        cpu_pkg::word_t    offs;
        cpu_pkg::word_t    instr;
        cpu_pkg::word_t    a;
        cpu_pkg::word_t    b;
        cpu_pkg::word_t    imm;
        cpu_pkg::word_t    addr;
        cpu_pkg::word_t    result;
        cpu_pkg::reg_idx_t rd;
        logic              write;
        int                steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc           = RESET_PC;
        n_writes     = 0;
        n_stores     = 0;
        reached_loop = 1'b0;
        steps        = 0;
        while (!reached_loop && steps < 1024) begin  // Forward-only code, bounded
            offs    = pc - RESET_PC;
            instr   = imem[offs[9:2]];
            rd      = instr[11:7];
            a       = regs[instr[19:15]];
            b       = regs[instr[24:20]];
            write   = 1'b0;
            result  = '0;
            next_pc = pc + 32'd4;
            case (instr[6:0])
                cpu_pkg::OP_R: begin
                    write = 1'b1;
                    case ({instr[31:25], instr[14:12]})
                        {7'h00, 3'b000}: result = a + b;
                        {7'h20, 3'b000}: result = a - b;
                        {7'h00, 3'b111}: result = a & b;
                        {7'h00, 3'b110}: result = a | b;
                        {7'h00, 3'b100}: result = a ^ b;
                        {7'h00, 3'b010}: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:         write = 1'b0;  // Outside the subset
                    endcase
                end
                cpu_pkg::OP_I: begin  // ADDI
                    imm    = {{20{instr[31]}}, instr[31:20]};
                    result = a + imm;
                    write  = 1'b1;
                end
                cpu_pkg::OP_LOAD: begin
                    imm    = {{20{instr[31]}}, instr[31:20]};
                    addr   = a + imm;
                    result = dmem[addr[7:2]];
                    write  = 1'b1;
                end
                cpu_pkg::OP_STORE: begin
                    imm                = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                    addr               = a + imm;
                    dmem[addr[7:2]]    = b;
                    st_addr[n_stores]  = addr;
                    st_data[n_stores]  = b;
                    n_stores++;
                end
                cpu_pkg::OP_BRANCH: begin
                    imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
                    if ((a == b) != instr[12]) begin  // funct3 bit 0 marks BNE
                        next_pc = pc + imm;
                    end
                end
                cpu_pkg::OP_JAL: begin
                    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                           instr[30:21], 1'b0};
                    if (imm == '0) begin
                        reached_loop = 1'b1;  // End of program
                    end else begin
                        result  = pc + 32'd4;  // Link value
                        write   = 1'b1;
                        next_pc = pc + imm;
                    end
                end
                default: ;
            endcase
            if (write && rd != '0) begin
                regs[rd]            = result;
                exp_rd[n_writes]    = rd;
                exp_wdata[n_writes] = result;
                n_writes++;
            end
            pc = next_pc;
            steps++;
        end
    endtask

endmodule

`default_nettype wire

/* bench/tb_pipe_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_core;

    localparam cpu_pkg::word_t RESET_PC   = 32'h0000_1000;
    localparam int             PROG_WORDS = 256;
    localparam int             DATA_WORDS = 64;
    localparam cpu_pkg::word_t SELF_LOOP  = 32'h0000_006f;  // JAL x0, 0
    localparam cpu_pkg::word_t LOOP_ADDR  = RESET_PC + 4 * (PROG_WORDS - 1);
    localparam int             WATCHDOG_NS = (PROG_WORDS * 20 + 4) * 10;

    logic              clk;
    logic              rst;
    cpu_pkg::word_t    imem_addr;
    cpu_pkg::word_t    imem_data;
    cpu_pkg::word_t    imem_offs;
    cpu_pkg::word_t    dmem_addr;
    cpu_pkg::word_t    dmem_wdata;
    cpu_pkg::word_t    dmem_rdata;
    logic              dmem_we;
    logic              dmem_re;
    logic              wb_valid;
    cpu_pkg::reg_idx_t wb_rd;
    cpu_pkg::word_t    wb_data;

    cpu_pkg::word_t prog [PROG_WORDS];
    cpu_pkg::word_t data_mem [DATA_WORDS];
    integer         seed = 32'ha3a0_a7e3;
    int             wb_count = 0;
    int             st_count = 0;
    logic           loop_seen = 1'b0;
    logic           pend_we = 1'b0;     // Store seen this cycle, lands at next edge
    logic [5:0]     pend_idx;
    cpu_pkg::word_t pend_data;

    pipe_core #(.RESET_PC(RESET_PC)) pipe_core_inst (
        .clk (clk), .rst (rst),
        .imem_addr (imem_addr), .imem_data (imem_data),
        .dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata),
        .dmem_we (dmem_we), .dmem_re (dmem_re), .dmem_rdata (dmem_rdata),
        .wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data)
    );

    core_model #(.RESET_PC(RESET_PC)) core_model_inst ();

    // Combinational memories
    assign imem_offs  = imem_addr - RESET_PC;
    assign imem_data  = prog[imem_offs[9:2]];  // Wraps past the end, wrong path only
    assign dmem_rdata = dmem_re ? data_mem[dmem_addr[7:2]] : 'x;  // Data only on a read

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // Reporting
    ////////////////////
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input cpu_pkg::word_t got,
                               input cpu_pkg::word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail: time %0t signal %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    ////////////////////
    // Program generation
    ////////////////////
    function automatic int rand_below(input int n);
        rand_below = $unsigned($random(seed)) % n;
    endfunction

    function automatic cpu_pkg::word_t random_instr(input int idx);
        int                kind;
        int                span;
        cpu_pkg::reg_idx_t rd;
        cpu_pkg::reg_idx_t rs1;
        cpu_pkg::reg_idx_t rs2;
        logic [11:0]       imm12;
        logic [12:0]       boff;
        logic [20:0]       joff;
        kind  = rand_below(12);
        rd    = 5'(rand_below(8));  // x0..x7 for dense hazards
        rs1   = 5'(rand_below(8));
        rs2   = 5'(rand_below(8));
        span  = (PROG_WORDS - 1 - idx < 6) ? PROG_WORDS - 1 - idx : 6;
        imm12 = 12'(rand_below(DATA_WORDS) * 4);  // x0-based data window
        boff  = 13'((1 + rand_below(span)) * 4);  // Forward only
        joff  = 21'((1 + rand_below(span)) * 4);
        case (kind)
            0:  random_instr = {7'h00, rs2, rs1, 3'b000, rd, cpu_pkg::OP_R};
            1:  random_instr = {7'h20, rs2, rs1, 3'b000, rd, cpu_pkg::OP_R};
            2:  random_instr = {7'h00, rs2, rs1, 3'b111, rd, cpu_pkg::OP_R};
            3:  random_instr = {7'h00, rs2, rs1, 3'b110, rd, cpu_pkg::OP_R};
            4:  random_instr = {7'h00, rs2, rs1, 3'b100, rd, cpu_pkg::OP_R};
            5:  random_instr = {7'h00, rs2, rs1, 3'b010, rd, cpu_pkg::OP_R};
            6:  random_instr = {12'(rand_below(4096)), rs1, 3'b000, rd, cpu_pkg::OP_I};
            7:  random_instr = {imm12, 5'd0, 3'b010, rd, cpu_pkg::OP_LOAD};
            8:  random_instr = {imm12[11:5], rs2, 5'd0, 3'b010, imm12[4:0], cpu_pkg::OP_STORE};
            9, 10: begin
                random_instr = {boff[12], boff[10:5], rs2, rs1, 3'(kind - 9),
                                boff[4:1], boff[11], cpu_pkg::OP_BRANCH};
            end
            default: begin
                random_instr = {joff[20], joff[10:1], joff[11], joff[19:12], rd,
                                cpu_pkg::OP_JAL};
            end
        endcase
    endfunction

    task automatic build_program();
        for (int i = 0; i < PROG_WORDS - 1; i++) begin
            prog[i] = random_instr(i);
        end
        prog[PROG_WORDS - 1] = SELF_LOOP;
        for (int i = 0; i < DATA_WORDS; i++) begin
            data_mem[i] = i * 32'h9e37_79b9 + 32'h1357_0000;  // Every word distinct
        end
        for (int i = 0; i < PROG_WORDS; i++) begin
            core_model_inst.imem[i] = prog[i];
        end
        for (int i = 0; i < DATA_WORDS; i++) begin
            core_model_inst.dmem[i] = data_mem[i];
        end
    endtask

    ////////////////////
    // Monitors
    ////////////////////
    always @(negedge clk) begin
        if (!rst) begin
            if (wb_valid) begin
                if (wb_count >= core_model_inst.n_writes) begin
                    abort_run("Register write seen after the expected sequence ended");
                end else begin
                    check_value("wb_rd", wb_rd, core_model_inst.exp_rd[wb_count]);
                    check_value("wb_data", wb_data, core_model_inst.exp_wdata[wb_count]);
                    wb_count++;
                end
            end
            if (dmem_we) begin
                if (st_count >= core_model_inst.n_stores) begin
                    abort_run("Store seen after the expected sequence ended");
                end else begin
                    check_value("dmem_addr", dmem_addr, core_model_inst.st_addr[st_count]);
                    check_value("dmem_wdata", dmem_wdata, core_model_inst.st_data[st_count]);
                    st_count++;
                    pend_we   = 1'b1;
                    pend_idx  = dmem_addr[7:2];
                    pend_data = dmem_wdata;
                end
            end
            if (dmem_re) begin
                check_value("dmem_addr[1:0]", dmem_addr[1:0], '0);  // Word aligned
                check_value("dmem_addr[31:8]", dmem_addr[31:8], '0);  // Inside window
            end
            if (imem_addr == LOOP_ADDR) begin
                loop_seen = 1'b1;
            end
        end
    end

    // Store lands just after the edge that ends its cycle
    always @(posedge clk) begin
        #1;
        if (pend_we) begin
            data_mem[pend_idx] = pend_data;
            pend_we = 1'b0;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Watchdog expired before the core reached the self-loop");
    end

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        rst = 1'b1;
        build_program();
        core_model_inst.run();
        if (!core_model_inst.reached_loop) begin
            abort_run("Reference model never reached the self-loop");
        end else begin
            repeat (3) @(posedge clk);
            @(negedge clk);
            check_value("imem_addr", imem_addr, RESET_PC);  // State under reset
            check_value("wb_valid", wb_valid, '0);
            check_value("dmem_we", dmem_we, '0);
            check_value("dmem_re", dmem_re, '0);
            @(posedge clk);
            #1 rst = 1'b0;
            while (!loop_seen) begin
                @(posedge clk);
            end
            repeat (8) @(posedge clk);  // Last instructions drain, nothing more may retire
            if (wb_count == core_model_inst.n_writes && st_count == core_model_inst.n_stores) begin
                $display("Test passed");
                $finish;
            end else begin
                abort_run("Write or store count differs from the reference model");
            end
        end
    end

endmodule

`default_nettype wire

/* design/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    ////////////////////
    // Base types
    ////////////////////
    typedef logic [31:0] word_t;     // Data and address word
    typedef logic [4:0]  reg_idx_t;  // x0..x31

    // ALU operation select
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5   // Signed compare
    } alu_op_t;

    ////////////////////
    // RV32I major opcodes
    ////////////////////
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    ////////////////////
    // Pipeline bundles
    ////////////////////
    typedef struct packed {
        reg_idx_t dest_reg;   // Register to write
        logic     reg_write;  // Only set for rd != x0
        logic     mem_read;
        logic     mem_write;
        alu_op_t  alu_op;
        logic     alu_src;    // Immediate as second operand
        logic     wb_src;     // Memory data instead of ALU
        logic     branch;
        logic     branch_ne;  // BNE instead of BEQ
        logic     jump;
    } ctrl_t;

    typedef struct packed {
        word_t    pc;
        word_t    rdata1;
        word_t    rdata2;
        word_t    immd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        ctrl_t    ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t pc4;         // Link value for JAL
        word_t alu_result;  // Also the memory address
        word_t store_data;
        ctrl_t ctrl;
    } ex_mem_t;

    typedef struct packed {
        word_t pc4;
        word_t alu_result;
        word_t mem_data;
        ctrl_t ctrl;
    } mem_wb_t;

endpackage

`default_nettype wire

/* design/decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  cpu_pkg::word_t    instr,
    output cpu_pkg::ctrl_t    ctrl,
    output cpu_pkg::word_t    immd,
    output cpu_pkg::reg_idx_t rs1,
    output cpu_pkg::reg_idx_t rs2,
    output logic              use_rs1,  // Instruction really reads rs1
    output logic              use_rs2
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    cpu_pkg::reg_idx_t rd;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    ////////////////////
    // Control and immediate
    ////////////////////
    always_comb begin
        ctrl    = '0;  // Unknown encodings stay a bubble
        immd    = '0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            cpu_pkg::OP_R: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                ctrl.reg_write = (rd != '0);
                ctrl.dest_reg  = rd;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: ctrl.alu_op = cpu_pkg::ALU_ADD;
                    {7'h20, 3'b000}: ctrl.alu_op = cpu_pkg::ALU_SUB;
                    {7'h00, 3'b111}: ctrl.alu_op = cpu_pkg::ALU_AND;
                    {7'h00, 3'b110}: ctrl.alu_op = cpu_pkg::ALU_OR;
                    {7'h00, 3'b100}: ctrl.alu_op = cpu_pkg::ALU_XOR;
                    {7'h00, 3'b010}: ctrl.alu_op = cpu_pkg::ALU_SLT;
                    default: begin
                        ctrl    = '0;  // Not in the subset
                        use_rs1 = 1'b0;
                        use_rs2 = 1'b0;
                    end
                endcase
            end
            cpu_pkg::OP_I: begin
                if (funct3 == 3'b000) begin  // ADDI only
                    use_rs1 = 1'b1;
                    ctrl.reg_write = (rd != '0);
                    ctrl.dest_reg  = rd;
                    ctrl.alu_src   = 1'b1;
                    immd = {{20{instr[31]}}, instr[31:20]};
                end
            end
            cpu_pkg::OP_LOAD: begin
                if (funct3 == 3'b010) begin  // LW
                    use_rs1 = 1'b1;
                    ctrl.reg_write = (rd != '0);
                    ctrl.dest_reg  = rd;
                    ctrl.mem_read  = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    ctrl.wb_src    = 1'b1;
                    immd = {{20{instr[31]}}, instr[31:20]};
                end
            end
            cpu_pkg::OP_STORE: begin
                if (funct3 == 3'b010) begin  // SW
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;  // Store data
                    ctrl.mem_write = 1'b1;
                    ctrl.alu_src   = 1'b1;
                    immd = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                end
            end
            cpu_pkg::OP_BRANCH: begin
                if (funct3 == 3'b000 || funct3 == 3'b001) begin  // BEQ, BNE
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                    ctrl.branch    = 1'b1;
                    ctrl.branch_ne = funct3[0];
                    immd = {{19{instr[31]}}, instr[31], instr[7],
                            instr[30:25], instr[11:8], 1'b0};
                end
            end
            cpu_pkg::OP_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.reg_write = (rd != '0);  // JAL x0 is a plain jump
                ctrl.dest_reg  = rd;
                immd = {{11{instr[31]}}, instr[31], instr[19:12],
                        instr[20], instr[30:21], 1'b0};
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* design/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  cpu_pkg::id_ex_t ex,
    output cpu_pkg::word_t  alu_result,
    output logic            redirect,     // Taken branch or jump
    output cpu_pkg::word_t  redirect_pc
);

    cpu_pkg::word_t op_a;
    cpu_pkg::word_t op_b;
    logic           equal;
    logic           taken;

    assign op_a = ex.rdata1;
    assign op_b = ex.ctrl.alu_src ? ex.immd : ex.rdata2;  // Immediate or rs2

    ////////////////////
    // ALU
    ////////////////////
    always_comb begin
        case (ex.ctrl.alu_op)
            cpu_pkg::ALU_ADD: alu_result = op_a + op_b;
            cpu_pkg::ALU_SUB: alu_result = op_a - op_b;
            cpu_pkg::ALU_AND: alu_result = op_a & op_b;
            cpu_pkg::ALU_OR:  alu_result = op_a | op_b;
            cpu_pkg::ALU_XOR: alu_result = op_a ^ op_b;
            cpu_pkg::ALU_SLT: begin
                // Signed less-than, result is 0 or 1
                alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
            end
            default: alu_result = op_a + op_b;
        endcase
    end

    ////////////////////
    // Branch and jump
    ////////////////////
    assign equal = (ex.rdata1 == ex.rdata2);  // Always registers, never immd

    // BNE inverts the compare
    assign taken = ex.ctrl.branch & (equal ^ ex.ctrl.branch_ne);

    assign redirect    = taken | ex.ctrl.jump;
    assign redirect_pc = ex.pc + ex.immd;  // Same target form for B and J

endmodule

`default_nettype wire

/* design/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  cpu_pkg::reg_idx_t rs1,
    input  cpu_pkg::reg_idx_t rs2,
    input  logic              use_rs1,
    input  logic              use_rs2,
    input  cpu_pkg::ctrl_t    ex_ctrl,   // Instruction in execute
    input  cpu_pkg::ctrl_t    mem_ctrl,  // Instruction in memory
    input  logic              redirect,
    output logic              stall,
    output logic              flush
);

    logic raw_rs1;
    logic raw_rs2;

    // Source matches a pending write still ahead of writeback
    assign raw_rs1 = use_rs1 && (rs1 != '0) &&
                     ((ex_ctrl.reg_write  && ex_ctrl.dest_reg  == rs1) ||
                      (mem_ctrl.reg_write && mem_ctrl.dest_reg == rs1));
    assign raw_rs2 = use_rs2 && (rs2 != '0) &&
                     ((ex_ctrl.reg_write  && ex_ctrl.dest_reg  == rs2) ||
                      (mem_ctrl.reg_write && mem_ctrl.dest_reg == rs2));

    ////////////////////
    // Priority
    ////////////////////
    assign flush = redirect;                          // Decode is wrong path
    assign stall = (raw_rs1 | raw_rs2) & ~redirect;   // No point holding it

    // Both at once would hold a wrong-path instruction in IF/ID
    always_comb begin
        a_no_stall_flush: assert final (!(stall && flush));
    end

endmodule

`default_nettype wire

/* design/id_ex_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
    input  logic            clk,
    input  logic            rst,
    input  logic            bubble,  // Stall or flush from hazard unit
    input  cpu_pkg::id_ex_t d,
    output cpu_pkg::id_ex_t q
);

    ////////////////////
    // Decode to execute
    ////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q <= '0;  // Starts as a bubble
        end else begin
            q <= d;
            if (bubble) begin
                q.ctrl <= '0;  // Data passes, control is killed
            end
        end
    end

    // A bubble never leaves a side effect in execute
    a_bubble_no_effect: assert property (@(posedge clk) disable iff (rst)
        bubble |=> !(q.ctrl.reg_write || q.ctrl.mem_read || q.ctrl.mem_write
                     || q.ctrl.branch || q.ctrl.jump));

endmodule

`default_nettype wire

/* design/pipe_core.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_core #(
    parameter cpu_pkg::word_t RESET_PC = '0
) (
    input  logic              clk,
    input  logic              rst,
    output cpu_pkg::word_t    imem_addr,
    input  cpu_pkg::word_t    imem_data,
    output cpu_pkg::word_t    dmem_addr,
    output cpu_pkg::word_t    dmem_wdata,
    output logic              dmem_we,
    output logic              dmem_re,
    input  cpu_pkg::word_t    dmem_rdata,
    output logic              wb_valid,
    output cpu_pkg::reg_idx_t wb_rd,
    output cpu_pkg::word_t    wb_data
);

    cpu_pkg::word_t    pc;
    cpu_pkg::word_t    if_id_pc;
    cpu_pkg::word_t    if_id_instr;
    cpu_pkg::ctrl_t    dec_ctrl;
    cpu_pkg::word_t    dec_immd;
    cpu_pkg::reg_idx_t dec_rs1;
    cpu_pkg::reg_idx_t dec_rs2;
    logic              dec_use_rs1;
    logic              dec_use_rs2;
    cpu_pkg::word_t    rf_rdata1;
    cpu_pkg::word_t    rf_rdata2;
    cpu_pkg::id_ex_t   id_ex_d;
    cpu_pkg::id_ex_t   id_ex_q;
    cpu_pkg::word_t    alu_result;
    logic              redirect;
    cpu_pkg::word_t    redirect_pc;
    logic              stall;
    logic              flush;
    cpu_pkg::ex_mem_t  ex_mem;
    cpu_pkg::mem_wb_t  mem_wb;

    ////////////////////
    // Fetch
    ////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;  // Branch or jump from execute
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    assign imem_addr = pc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_id_pc    <= '0;
            if_id_instr <= '0;  // Opcode 0 decodes as a bubble
        end else if (flush) begin
            if_id_pc    <= '0;
            if_id_instr <= '0;  // Kill wrong-path fetch
        end else if (!stall) begin
            if_id_pc    <= pc;
            if_id_instr <= imem_data;
        end
    end

    ////////////////////
    // Decode
    ////////////////////
    decode_unit decode_unit_inst (
        .instr   (if_id_instr),
        .ctrl    (dec_ctrl),
        .immd    (dec_immd),
        .rs1     (dec_rs1),
        .rs2     (dec_rs2),
        .use_rs1 (dec_use_rs1),
        .use_rs2 (dec_use_rs2)
    );

    reg_file reg_file_inst (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (dec_rs1),
        .raddr2 (dec_rs2),
        .waddr  (wb_rd),
        .we     (wb_valid),
        .wdata  (wb_data),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    hazard_unit hazard_unit_inst (
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .use_rs1  (dec_use_rs1),
        .use_rs2  (dec_use_rs2),
        .ex_ctrl  (id_ex_q.ctrl),
        .mem_ctrl (ex_mem.ctrl),
        .redirect (redirect),
        .stall    (stall),
        .flush    (flush)
    );

    assign id_ex_d = '{pc: if_id_pc, rdata1: rf_rdata1, rdata2: rf_rdata2, immd: dec_immd,
                       rs1: dec_rs1, rs2: dec_rs2, ctrl: dec_ctrl};

    id_ex_reg id_ex_reg_inst (
        .clk    (clk),
        .rst    (rst),
        .bubble (stall | flush),
        .d      (id_ex_d),
        .q      (id_ex_q)
    );

    ////////////////////
    // Execute
    ////////////////////
    exec_unit exec_unit_inst (
        .ex          (id_ex_q),
        .alu_result  (alu_result),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_mem <= '0;
        end else begin
            ex_mem.pc4        <= id_ex_q.pc + 32'd4;  // JAL link value
            ex_mem.alu_result <= alu_result;
            ex_mem.store_data <= id_ex_q.rdata2;
            ex_mem.ctrl       <= id_ex_q.ctrl;
        end
    end

    ////////////////////
    // Memory
    ////////////////////
    assign dmem_addr  = ex_mem.alu_result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_we    = ex_mem.ctrl.mem_write;
    assign dmem_re    = ex_mem.ctrl.mem_read;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wb <= '0;
        end else begin
            mem_wb.pc4        <= ex_mem.pc4;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.mem_data   <= dmem_rdata;  // Same-cycle read data
            mem_wb.ctrl       <= ex_mem.ctrl;
        end
    end

    ////////////////////
    // Writeback
    ////////////////////
    assign wb_valid = mem_wb.ctrl.reg_write && (mem_wb.ctrl.dest_reg != '0);
    assign wb_rd    = mem_wb.ctrl.dest_reg;
    assign wb_data  = mem_wb.ctrl.wb_src ? mem_wb.mem_data :
                      mem_wb.ctrl.jump   ? mem_wb.pc4      : mem_wb.alu_result;

endmodule

`default_nettype wire

/* design/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  cpu_pkg::reg_idx_t raddr1,
    input  cpu_pkg::reg_idx_t raddr2,
    input  cpu_pkg::reg_idx_t waddr,
    input  logic              we,
    input  cpu_pkg::word_t    wdata,
    output cpu_pkg::word_t    rdata1,
    output cpu_pkg::word_t    rdata2
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin  // x0 never written
            regs[waddr] <= wdata;
        end
    end

    // Write-first bypass, so writeback never stalls decode
    assign rdata1 = (raddr1 == '0)                ? '0    :
                    (we && waddr == raddr1)       ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0)                ? '0    :
                    (we && waddr == raddr2)       ? wdata : regs[raddr2];

    // x0 reads zero on both ports, even while x0 is the write target
    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        regs[0] == '0 && (raddr1 != '0 || rdata1 == '0) && (raddr2 != '0 || rdata2 == '0));

endmodule

`default_nettype wire

/* verilog.f */
design/cpu_pkg.sv
design/decode_unit.sv
design/reg_file.sv
design/id_ex_reg.sv
design/exec_unit.sv
design/hazard_unit.sv
design/pipe_core.sv
bench/core_model.sv
bench/tb_pipe_core.sv
